//--- src/cargoPkg.sv
package cargoPkg;

    // floors are numbered 0 to 3, bottom up
    typedef logic [1:0] floorNum;

    localparam int floorCount = 4; // one sensor line per floor

    typedef enum logic [1:0] {
        dirStop = 2'd0,
        dirUp   = 2'd1,
        dirDown = 2'd2
    } dirKind;

    typedef enum logic [1:0] {
        stIdle   = 2'd0, // waiting for a stop
        stMoving = 2'd1, // motor running toward head
        stDwell  = 2'd2, // loading or unloading
        stHalted = 2'd3  // emergency stop
    } motionState;

endpackage

//--- src/cargoRegPkg.sv
package cargoRegPkg;

    localparam int addrWidth = 4;
    localparam int dataWidth = 32;
    localparam int countFieldWidth = 8; // queue count slot in status

    // word addresses
    localparam logic [addrWidth-1:0] regCtrlAddr    = 4'h0;
    localparam logic [addrWidth-1:0] regRequestAddr = 4'h4;
    localparam logic [addrWidth-1:0] regStatusAddr  = 4'h8;

    typedef struct packed {
        logic [28:0] reserved;
        logic        clearQueue; // self clearing
        logic        emergency;
        logic        start;
    } ctrlView;

    typedef struct packed {
        logic [27:0]       reserved;
        cargoPkg::floorNum dest;
        cargoPkg::floorNum origin;
    } requestView;

    // same write word, meaning depends on paddr
    typedef union packed {
        ctrlView    ctrl;
        requestView request;
    } apbWord;

endpackage

//--- src/cargoApbRegs.sv
`timescale 1ns/1ps
module cargoApbRegs #(
    parameter int queueDepth = 8
) (
    input  logic                               clock,
    input  logic                               rst,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [cargoRegPkg::addrWidth-1:0]  paddr,
    input  logic [cargoRegPkg::dataWidth-1:0]  pwdata,
    output logic [cargoRegPkg::dataWidth-1:0]  prdata,
    output logic                               pready,
    output logic                               pslverr,
    input  logic [$clog2(queueDepth+1)-1:0]    freeSlots,
    input  cargoPkg::floorNum                  curFloor,
    input  cargoPkg::floorNum                  headFloor,
    input  logic                               headValid,
    input  logic [$clog2(queueDepth+1)-1:0]    queueCount,
    input  cargoPkg::dirKind                   direction,
    output logic                               runEnable,
    output logic                               emergency,
    output logic                               pushReq,
    output cargoPkg::floorNum                  pushOrigin,
    output cargoPkg::floorNum                  pushDest,
    output logic                               clearReq
);
    localparam int countWidth = $clog2(queueDepth + 1);
    localparam int countField = cargoRegPkg::countFieldWidth;
    localparam int dataW = cargoRegPkg::dataWidth;

    cargoRegPkg::apbWord wordIn;
    logic access, isCtrl, isRequest, isStatus, writeOk;
    logic [dataW-1:0] statusWord;

    assign wordIn = pwdata;
    assign access = psel && penable;
    assign isCtrl = paddr == cargoRegPkg::regCtrlAddr;
    assign isRequest = paddr == cargoRegPkg::regRequestAddr;
    assign isStatus = paddr == cargoRegPkg::regStatusAddr;

    // a request always needs room for two stops
    assign pslverr = access && (!(isCtrl || isRequest || isStatus)
                     || (pwrite && isStatus)
                     || (pwrite && isRequest && freeSlots < countWidth'(2)));
    assign pready = 1'b1; // no wait states
    assign writeOk = access && pwrite && !pslverr;

    assign pushReq = writeOk && isRequest;
    assign pushOrigin = wordIn.request.origin;
    assign pushDest = wordIn.request.dest;
    assign clearReq = writeOk && isCtrl && wordIn.ctrl.clearQueue;

    always_ff @(posedge clock) begin
        if (rst) begin
            runEnable <= 1'b0;
            emergency <= 1'b0;
        end else if (writeOk && isCtrl) begin
            runEnable <= wordIn.ctrl.start;
            emergency <= wordIn.ctrl.emergency;
        end
    end

    assign statusWord = dataW'({countField'(queueCount), direction, emergency,
                                headValid, headFloor, curFloor});

    always_comb begin
        if (isStatus) prdata = statusWord;
        else if (isCtrl) prdata = dataW'({emergency, runEnable});
        else prdata = '0; // request reads back zero
    end
endmodule

//--- src/requestQueue.sv
`timescale 1ns/1ps
module requestQueue #(
    parameter int queueDepth = 8
) (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            pushReq,
    input  cargoPkg::floorNum               pushOrigin,
    input  cargoPkg::floorNum               pushDest,
    input  logic                            clearReq,
    input  logic                            popStop,
    output logic                            headValid,
    output cargoPkg::floorNum               headFloor,
    output logic [$clog2(queueDepth+1)-1:0] queueCount,
    output logic [$clog2(queueDepth+1)-1:0] freeSlots
);
    localparam int ptrWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int countWidth = $clog2(queueDepth + 1);

    cargoPkg::floorNum slots [queueDepth];
    logic [ptrWidth-1:0] headPtr, tailPtr, tailNext;
    logic [countWidth-1:0] count;
    logic doPop, newestLive, keepOrigin, keepDest;
    logic [countWidth-1:0] pushN;
    cargoPkg::floorNum newest;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(queueDepth - 1)) return '0;
        return ptr + 1'b1;
    endfunction

    function automatic logic [ptrWidth-1:0] prevPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == '0) return ptrWidth'(queueDepth - 1);
        return ptr - 1'b1;
    endfunction

    assign doPop = popStop && count != '0;
    assign newest = slots[prevPtr(tailPtr)];
    // last entry leaving this cycle is not a merge target
    assign newestLive = count > (doPop ? countWidth'(1) : countWidth'(0));

    assign keepOrigin = !(newestLive && pushOrigin == newest);
    assign keepDest = pushDest != pushOrigin;
    assign pushN = pushReq ? countWidth'(keepOrigin) + countWidth'(keepDest) : '0;
    assign tailNext = keepOrigin ? nextPtr(tailPtr) : tailPtr;

    always_ff @(posedge clock) begin
        if (pushReq && keepOrigin) slots[tailPtr] <= pushOrigin;
        if (pushReq && keepDest) slots[tailNext] <= pushDest;
    end

    always_ff @(posedge clock) begin
        if (rst || clearReq) begin // clear beats push and pop
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPop) headPtr <= nextPtr(headPtr);
            if (pushReq) tailPtr <= keepDest ? nextPtr(tailNext) : tailNext;
            count <= count + pushN - countWidth'(doPop);
        end
    end

    assign headValid = count != '0;
    assign headFloor = slots[headPtr];
    assign queueCount = count;
    assign freeSlots = countWidth'(queueDepth) - count;
endmodule

//--- src/motionControl.sv
`timescale 1ns/1ps
module motionControl #(
    parameter int dwellCycles = 20
) (
    input  logic                           clock,
    input  logic                           rst,
    input  logic [cargoPkg::floorCount-1:0] sensorsN,
    input  logic                           runEnable,
    input  logic                           emergency,
    input  logic                           headValid,
    input  cargoPkg::floorNum              headFloor,
    output cargoPkg::floorNum              curFloor,
    output cargoPkg::dirKind               direction,
    output logic                           motorUp,
    output logic                           motorDown,
    output logic                           popStop
);
    localparam int timerWidth = $clog2(dwellCycles + 1);

    cargoPkg::motionState state;
    logic [timerWidth-1:0] timer;
    logic sensorHit;
    cargoPkg::floorNum sensorFloor;

    // only a single low line counts as a floor
    always_comb begin
        sensorHit = 1'b0;
        sensorFloor = '0;
        for (int i = 0; i < cargoPkg::floorCount; i++) begin
            if (sensorsN == ~(cargoPkg::floorCount'(1) << i)) begin
                sensorHit = 1'b1;
                sensorFloor = cargoPkg::floorNum'(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) curFloor <= '0;
        else if (sensorHit) curFloor <= sensorFloor;
    end

    assign popStop = state == cargoPkg::stDwell && !emergency
                     && timer == timerWidth'(dwellCycles - 1);

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= cargoPkg::stIdle;
            direction <= cargoPkg::dirStop;
            timer <= '0;
        end else if (emergency) begin
            state <= cargoPkg::stHalted;
            direction <= cargoPkg::dirStop;
            timer <= '0;
        end else begin
            case (state)
                cargoPkg::stIdle: if (headValid && runEnable) begin
                    if (headFloor == curFloor) state <= cargoPkg::stDwell;
                    else begin
                        state <= cargoPkg::stMoving;
                        direction <= (headFloor > curFloor) ? cargoPkg::dirUp
                                                            : cargoPkg::dirDown;
                    end
                end
                cargoPkg::stMoving: begin
                    if (!headValid) begin // queue cleared under us
                        state <= cargoPkg::stIdle;
                        direction <= cargoPkg::dirStop;
                    end else if (sensorHit && sensorFloor == headFloor) begin
                        state <= cargoPkg::stDwell;
                        direction <= cargoPkg::dirStop;
                    end
                end
                cargoPkg::stDwell: begin
                    timer <= timer + 1'b1;
                    if (popStop) begin
                        state <= cargoPkg::stIdle;
                        timer <= '0;
                    end
                end
                default: state <= cargoPkg::stIdle; // halted and released
            endcase
        end
    end

    // emergency also cuts the drive directly
    assign motorUp = state == cargoPkg::stMoving && direction == cargoPkg::dirUp && !emergency;
    assign motorDown = state == cargoPkg::stMoving && direction == cargoPkg::dirDown
                       && !emergency;
endmodule

//--- src/smartCargo.sv
`timescale 1ns/1ps
module smartCargo #(
    parameter int queueDepth = 8,
    parameter int dwellCycles = 20
) (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [cargoRegPkg::addrWidth-1:0] paddr,
    input  logic [cargoRegPkg::dataWidth-1:0] pwdata,
    output logic [cargoRegPkg::dataWidth-1:0] prdata,
    output logic                              pready,
    output logic                              pslverr,
    input  logic [cargoPkg::floorCount-1:0]   sensorsN,
    output logic                              motorUp,
    output logic                              motorDown
);
    localparam int countWidth = $clog2(queueDepth + 1);

    logic runEnable, emergency, pushReq, clearReq, popStop, headValid;
    cargoPkg::floorNum pushOrigin, pushDest, headFloor, curFloor;
    cargoPkg::dirKind direction;
    logic [countWidth-1:0] queueCount, freeSlots;

    cargoApbRegs #(.queueDepth(queueDepth)) apbRegs_inst (
        .clock      (clock),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .freeSlots  (freeSlots),
        .curFloor   (curFloor),
        .headFloor  (headFloor),
        .headValid  (headValid),
        .queueCount (queueCount),
        .direction  (direction),
        .runEnable  (runEnable),
        .emergency  (emergency),
        .pushReq    (pushReq),
        .pushOrigin (pushOrigin),
        .pushDest   (pushDest),
        .clearReq   (clearReq)
    );

    requestQueue #(.queueDepth(queueDepth)) queue_inst (
        .clock      (clock),
        .rst        (rst),
        .pushReq    (pushReq),
        .pushOrigin (pushOrigin),
        .pushDest   (pushDest),
        .clearReq   (clearReq),
        .popStop    (popStop),     // retire head after dwell
        .headValid  (headValid),
        .headFloor  (headFloor),
        .queueCount (queueCount),
        .freeSlots  (freeSlots)
    );

    motionControl #(.dwellCycles(dwellCycles)) motion_inst (
        .clock      (clock),
        .rst        (rst),
        .sensorsN   (sensorsN),
        .runEnable  (runEnable),
        .emergency  (emergency),
        .headValid  (headValid),
        .headFloor  (headFloor),
        .curFloor   (curFloor),
        .direction  (direction),
        .motorUp    (motorUp),
        .motorDown  (motorDown),
        .popStop    (popStop)
    );
endmodule

//--- tests/smartCargo_asserts.sv
`timescale 1ns/1ps
module smartCargo_asserts (
    input logic clock,
    input logic rst,
    input logic emergency,
    input logic motorUp,
    input logic motorDown,
    input logic popStop
);
    motorsExclusive: assert property (@(posedge clock) disable iff (rst)
        !(motorUp && motorDown))
        else $error("motorUp and motorDown are high together");

    emergencyCutsDrive: assert property (@(posedge clock) disable iff (rst)
        emergency |=> !motorUp && !motorDown)
        else $error("a motor is still driven one cycle after emergency");

    popStopPulse: assert property (@(posedge clock) disable iff (rst)
        popStop |=> !popStop)
        else $error("popStop is high for more than one cycle");
endmodule

bind motionControl smartCargo_asserts motionAsserts_inst (
    .clock     (clock),
    .rst       (rst),
    .emergency (emergency),
    .motorUp   (motorUp),
    .motorDown (motorDown),
    .popStop   (popStop)
);

//--- tests/smartCargoTb.sv
`timescale 1ns/1ps
module smartCargoTb;
    localparam int waitLimit = 300; // cycles or reads per wait loop

    logic clock = 1'b0;
    logic rst;
    logic psel;
    logic penable;
    logic pwrite;
    logic [cargoRegPkg::addrWidth-1:0] paddr;
    logic [cargoRegPkg::dataWidth-1:0] pwdata;
    logic [cargoRegPkg::dataWidth-1:0] prdata;
    logic pready;
    logic pslverr;
    logic [cargoPkg::floorCount-1:0] sensorsN;
    logic motorUp;
    logic motorDown;

    logic [1:0] carFloor = 2'd0; // where the sensor model has the car
    int stepCount = 0;
    int stepLimit = 4;
    integer seed = 32'h8e0;
    int errors = 0;
    int timeouts = 0;

    always #5 clock = ~clock;

    smartCargo #(.dwellCycles(6)) smartCargo_inst (
        .clock     (clock),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .sensorsN  (sensorsN),
        .motorUp   (motorUp),
        .motorDown (motorDown)
    );

    assign sensorsN = ~(cargoPkg::floorCount'(1) << carFloor); // one line low

    // car advances one floor every 4 to 6 cycles of motor drive
    always @(negedge clock) begin
        if (rst || !(motorUp || motorDown)) begin
            stepCount <= 0;
        end else if (stepCount + 1 >= stepLimit) begin
            if (motorUp && carFloor != 2'd3) carFloor <= carFloor + 2'd1;
            if (motorDown && carFloor != 2'd0) carFloor <= carFloor - 2'd1;
            stepCount <= 0;
            stepLimit <= 4 + int'($unsigned($random(seed)) % 3);
        end else begin
            stepCount <= stepCount + 1;
        end
    end

    function automatic logic [1:0] motorCode();
        return {motorDown, motorUp}; // same coding as dirKind
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] got);
        errors++;
        $display("error at %0d ns: %s expected %h got %h", $time, name, expected, got);
    endtask

    task automatic reportTimeout(input string what);
        timeouts++;
        $display("timeout at %0d ns while waiting for %s", $time, what);
    endtask

    task automatic apbAccess(input logic [3:0] addr, input logic [31:0] data,
                             input logic write, output logic err, output logic [31:0] rdata);
        @(negedge clock);
        psel = 1'b1; // setup phase
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = data;
        @(negedge clock);
        penable = 1'b1;
        #2;
        err = pslverr;
        rdata = prdata;
        assert (pready) else reportMismatch("pready", 32'd1, 32'd0);
        @(negedge clock);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic writeExpect(input logic [3:0] addr, input logic [31:0] data,
                               input logic expErr);
        logic err;
        logic [31:0] unused;
        apbAccess(addr, data, 1'b1, err, unused);
        assert (err == expErr) else reportMismatch("pslverr", 32'(expErr), 32'(err));
    endtask

    // status settles over time, so poll until it matches
    task automatic readExpect(input logic [3:0] addr, input logic [31:0] expected,
                              input logic [31:0] mask);
        logic err;
        logic [31:0] got;
        int n;
        n = 0;
        apbAccess(addr, 32'd0, 1'b0, err, got);
        while ((got & mask) !== expected && n < waitLimit) begin
            apbAccess(addr, 32'd0, 1'b0, err, got);
            n++;
        end
        assert ((got & mask) === expected) else reportMismatch("prdata", expected, got & mask);
        assert (!err) else reportMismatch("pslverr", 32'd0, 32'd1);
    endtask

    task automatic waitMotor(input logic [1:0] code);
        int n;
        n = 0;
        while (motorCode() != code && n < waitLimit) begin
            @(negedge clock);
            n++;
        end
        assert (motorCode() == code) else reportTimeout("the requested motor output");
    endtask

    task automatic travelExpect(input logic [1:0] dir, input logic [1:0] target);
        int n;
        n = 0;
        while (motorCode() == 2'b00 && n < waitLimit) begin
            @(negedge clock);
            n++;
        end
        assert (motorCode() != 2'b00) else reportTimeout("the motor to start");
        assert (motorCode() == dir) else reportMismatch("motor", 32'(dir), 32'(motorCode()));
        n = 0;
        while (motorCode() != 2'b00 && n < waitLimit) begin
            @(negedge clock);
            n++;
        end
        assert (motorCode() == 2'b00) else reportTimeout("the car to stop");
        assert (carFloor == target) else reportMismatch("carFloor", 32'(target), 32'(carFloor));
    endtask

    task automatic holdLow(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            assert (motorCode() == 2'b00) else reportMismatch("motor", 32'd0, 32'(motorCode()));
        end
    endtask

    initial begin
        int fd;
        int code;
        logic [63:0] opWord;
        logic [1023:0] lineBuf;
        logic [31:0] argA;
        logic [31:0] argB;
        logic [31:0] argC;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        rst = 1'b1;
        repeat (2) @(negedge clock);
        rst = 1'b0;
        fd = $fopen("tests/smartCargo_tests.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("could not open the stimulus file");
        end
        while (fd != 0 && !$feof(fd)) begin
            code = $fscanf(fd, "%s", opWord);
            if (code != 1) break;
            if (opWord == 64'("#")) begin
                code = $fgets(lineBuf, fd); // skip comment line
            end else if (opWord == 64'("write") || opWord == 64'("error")) begin
                code = $fscanf(fd, "%h %h", argA, argB);
                writeExpect(argA[3:0], argB, opWord == 64'("error"));
            end else if (opWord == 64'("read")) begin
                code = $fscanf(fd, "%h %h %h", argA, argB, argC);
                readExpect(argA[3:0], argB, argC);
            end else if (opWord == 64'("travel")) begin
                code = $fscanf(fd, "%h %h", argA, argB);
                travelExpect(argA[1:0], argB[1:0]);
            end else if (opWord == 64'("motor")) begin
                code = $fscanf(fd, "%h", argA);
                waitMotor(argA[1:0]);
            end else if (opWord == 64'("hold")) begin
                code = $fscanf(fd, "%h", argA);
                holdLow(int'(argA));
            end else begin
                errors++;
                $display("unknown operation %0s in the stimulus file", opWord);
            end
        end
        if (fd != 0) $fclose(fd);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end
endmodule

//--- tests/smartCargo_tests.txt
# write/error: addr data | read: addr expected mask | travel: dir floor | motor: dir | hold: cycles
# all values hex, dir 0 stop 1 up 2 down, request data is dest<<2 | origin
read 8 0 fff3
hold 2
write 0 1
write 4 2
travel 1 2
travel 2 0
read 8 0 fff3
write 4 d
travel 1 1
motor 1
write 0 3
hold 8
read 8 13c fffc
write 0 1
travel 1 3
read 8 3 fff3
write 0 0
write 4 5
write 4 9
read 8 217 ffff
write 4 c
write 4 c
write 4 c
error 4 c
error c 0
error 8 0
read 8 817 ffff
write 0 4
read 8 3 fff3
read 0 0 3

//--- smartCargo.f
src/cargoPkg.sv
src/cargoRegPkg.sv
src/cargoApbRegs.sv
src/requestQueue.sv
src/motionControl.sv
src/smartCargo.sv
tests/smartCargo_asserts.sv
tests/smartCargoTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Mdir obj_dir --top-module smartCargoTb \
        -f smartCargo.f \
    && ./obj_dir/VsmartCargoTb | tee /dev/stderr | grep "Result: PASSED" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
